// ==== source/muldiv_pkg.sv ====
package muldiv_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int XLEN           = 32;
  localparam int ACC_ID_WIDTH   = 5;
  localparam int ACC_ADDR_WIDTH = 2;

  // Iteration counter of the divider, one step per quotient bit
  localparam int DIV_CNT_WIDTH  = $clog2(XLEN);

  // Unit address on the offload bus
  localparam logic [ACC_ADDR_WIDTH-1:0] MULDIV_ADDR = 2'd0;

  // ----------------------------------------
  // Operation encoding
  // ----------------------------------------
  // Bit 2 set marks the divider class
  typedef enum logic [3:0] {
    MUL    = 4'd0,
    MULH   = 4'd1,
    MULHSU = 4'd2,
    MULHU  = 4'd3,
    DIV    = 4'd4,
    DIVU   = 4'd5,
    REM    = 4'd6,
    REMU   = 4'd7
  } muldiv_op_e;

endpackage

// ==== source/cc_types_pkg.sv ====
package cc_types_pkg;

  import muldiv_pkg::*;

  // ----------------------------------------
  // Path register switches
  // ----------------------------------------
  localparam bit REG_OFFLOAD_REQ  = 1'b1;
  localparam bit REG_OFFLOAD_RESP = 1'b1;
  localparam bit REG_TCDM_REQ     = 1'b0;
  localparam bit REG_TCDM_RESP    = 1'b1;

  // Offload request towards the accelerator
  typedef struct packed {
    logic [ACC_ADDR_WIDTH-1:0] addr;
    logic [ACC_ID_WIDTH-1:0]   id;
    muldiv_op_e                op;
    logic [XLEN-1:0]           arga;
    logic [XLEN-1:0]           argb;
  } acc_req_t;

  // Offload response, id is the destination register tag
  typedef struct packed {
    logic [XLEN-1:0]         data;
    logic [ACC_ID_WIDTH-1:0] id;
    logic                    error;
  } acc_resp_t;

  // TCDM request and response
  typedef struct packed {
    logic [31:0] addr;
    logic        write;
    logic [3:0]  amo;
    logic [31:0] data;
    logic [3:0]  strb;
  } dreq_t;

  typedef struct packed {
    logic [31:0] data;
    logic        error;
  } dresp_t;

endpackage

// ==== source/spill_register.sv ====
module spill_register #(
  parameter type T      = logic,
  parameter bit  BYPASS = 1'b0
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  if (BYPASS) begin : gen_bypass
    // Plain wires, no cut
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_spill
    logic a_full_q, b_full_q;
    T     a_data_q, b_data_q;
    logic a_fill, a_drain;
    logic b_fill, b_drain;

    // Slot A takes input, slot B catches A when the output stalls
    assign a_fill  = valid_i && ready_o;
    assign a_drain = a_full_q && !b_full_q;
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill || a_drain) begin
          a_full_q <= a_fill;
        end
        if (b_fill || b_drain) begin
          b_full_q <= b_fill;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    // B holds the older item whenever both are full
    assign valid_o = a_full_q || b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q;
    assign ready_o = !a_full_q || !b_full_q;
  end

endmodule

// ==== source/muldiv_multiplier.sv ====
module muldiv_multiplier import muldiv_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    valid_i,
  output logic                    ready_o,
  input  muldiv_op_e              op_i,
  input  logic [XLEN-1:0]         a_i,
  input  logic [XLEN-1:0]         b_i,
  input  logic [ACC_ID_WIDTH-1:0] id_i,
  output logic                    valid_o,
  input  logic                    ready_i,
  output logic [XLEN-1:0]         result_o,
  output logic [ACC_ID_WIDTH-1:0] id_o
);

  logic                     a_signed, b_signed;
  logic signed [XLEN:0]     a_ext, b_ext;
  logic signed [2*XLEN+1:0] product;

  logic                    s1_valid_q, s1_high_q;
  logic [2*XLEN-1:0]       s1_prod_q;
  logic [ACC_ID_WIDTH-1:0] s1_id_q;
  logic                    s2_valid_q;
  logic [XLEN-1:0]         s2_result_q;
  logic [ACC_ID_WIDTH-1:0] s2_id_q;
  logic                    s1_ready, s2_ready;

  // 33-bit operands cover all four signedness cases
  assign a_signed = (op_i == MULH) || (op_i == MULHSU);
  assign b_signed = (op_i == MULH);
  assign a_ext    = {a_signed & a_i[XLEN-1], a_i};
  assign b_ext    = {b_signed & b_i[XLEN-1], b_i};
  assign product  = a_ext * b_ext;

  // Stage advances when the next one is empty or draining
  assign s2_ready = !s2_valid_q || ready_i;
  assign s1_ready = !s1_valid_q || s2_ready;
  assign ready_o  = s1_ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      if (s1_ready) begin
        s1_valid_q <= valid_i;
      end
      if (s2_ready) begin
        s2_valid_q <= s1_valid_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && s1_ready) begin
      s1_prod_q <= product[2*XLEN-1:0];
      s1_high_q <= (op_i != MUL);
      s1_id_q   <= id_i;
    end
    // Word select in the second stage
    if (s1_valid_q && s2_ready) begin
      s2_result_q <= s1_high_q ? s1_prod_q[2*XLEN-1:XLEN] : s1_prod_q[XLEN-1:0];
      s2_id_q     <= s1_id_q;
    end
  end

  assign valid_o  = s2_valid_q;
  assign result_o = s2_result_q;
  assign id_o     = s2_id_q;

endmodule

// ==== source/muldiv_divider.sv ====
module muldiv_divider import muldiv_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    valid_i,
  output logic                    ready_o,
  input  muldiv_op_e              op_i,
  input  logic [XLEN-1:0]         a_i,
  input  logic [XLEN-1:0]         b_i,
  input  logic [ACC_ID_WIDTH-1:0] id_i,
  output logic                    valid_o,
  input  logic                    ready_i,
  output logic [XLEN-1:0]         result_o,
  output logic [ACC_ID_WIDTH-1:0] id_o
);

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } div_state_e;

  div_state_e               state_q;
  logic [DIV_CNT_WIDTH-1:0] count_q;
  logic [XLEN-1:0]          quot_q, rem_q, divisor_q;
  logic [ACC_ID_WIDTH-1:0]  id_q;
  logic                     rem_sel_q, quot_neg_q, rem_neg_q;

  logic            accept, div_zero;
  logic            op_signed, op_rem;
  logic            a_neg, b_neg;
  logic [XLEN-1:0] a_abs, b_abs;
  logic [XLEN:0]   shifted;
  logic [XLEN+1:0] diff;

  assign ready_o  = (state_q == IDLE);
  assign valid_o  = (state_q == DONE);
  assign accept   = valid_i && ready_o;
  assign div_zero = (b_i == '0);

  // Operand decode and magnitudes
  assign op_signed = (op_i == DIV) || (op_i == REM);
  assign op_rem    = (op_i == REM) || (op_i == REMU);
  assign a_neg     = op_signed && a_i[XLEN-1];
  assign b_neg     = op_signed && b_i[XLEN-1];
  assign a_abs     = a_neg ? -a_i : a_i;
  assign b_abs     = b_neg ? -b_i : b_i;

  // One restoring step, dividend bits shift in from the quotient register
  assign shifted = {rem_q, quot_q[XLEN-1]};
  assign diff    = {1'b0, shifted} - {2'b00, divisor_q};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      count_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            count_q <= '0;
            // Zero divisor needs no iterations
            state_q <= div_zero ? DONE : CALC;
          end
        end
        CALC: begin
          count_q <= count_q + 1'b1;
          if (count_q == DIV_CNT_WIDTH'(XLEN - 1)) begin
            state_q <= DONE;
          end
        end
        DONE: begin
          if (ready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q      <= id_i;
      rem_sel_q <= op_rem;
      if (div_zero) begin
        // RISC-V: quotient all ones, remainder is the dividend
        quot_q     <= '1;
        rem_q      <= a_i;
        quot_neg_q <= 1'b0;
        rem_neg_q  <= 1'b0;
      end else begin
        quot_q     <= a_abs;
        rem_q      <= '0;
        divisor_q  <= b_abs;
        quot_neg_q <= a_neg ^ b_neg;
        rem_neg_q  <= a_neg;
      end
    end else if (state_q == CALC) begin
      quot_q <= {quot_q[XLEN-2:0], !diff[XLEN+1]};
      rem_q  <= diff[XLEN+1] ? shifted[XLEN-1:0] : diff[XLEN-1:0];
    end
  end

  // Sign fix on the way out, min / -1 wraps back to the dividend
  always_comb begin
    if (rem_sel_q) begin
      result_o = rem_neg_q ? -rem_q : rem_q;
    end else begin
      result_o = quot_neg_q ? -quot_q : quot_q;
    end
  end

  assign id_o = id_q;

endmodule

// ==== source/shared_muldiv.sv ====
module shared_muldiv import muldiv_pkg::*; import cc_types_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  acc_req_t  req_i,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  output acc_resp_t resp_o,
  output logic      resp_valid_o,
  input  logic      resp_ready_i
);

  logic                    addr_ok, is_div;
  logic                    mul_in_valid, mul_in_ready;
  logic                    div_in_valid, div_in_ready;
  logic                    mul_out_valid, mul_out_ready;
  logic                    div_out_valid, div_out_ready;
  logic [XLEN-1:0]         mul_result, div_result;
  logic [ACC_ID_WIDTH-1:0] mul_id, div_id;
  logic                    err_accept, err_full_q;
  logic [ACC_ID_WIDTH-1:0] err_id_q;

  // ----------------------------------------
  // Decode and dispatch
  // ----------------------------------------
  assign addr_ok      = (req_i.addr == MULDIV_ADDR);
  assign is_div       = req_i.op inside {DIV, DIVU, REM, REMU};
  assign mul_in_valid = req_valid_i && addr_ok && !is_div;
  assign div_in_valid = req_valid_i && addr_ok && is_div;
  assign err_accept   = req_valid_i && !addr_ok && !err_full_q;

  always_comb begin
    if (!addr_ok) begin
      req_ready_o = !err_full_q;
    end else if (is_div) begin
      req_ready_o = div_in_ready;
    end else begin
      req_ready_o = mul_in_ready;
    end
  end

  muldiv_multiplier muldiv_multiplier_inst (
    .clk_i    ( clk_i         ),
    .rst_i    ( rst_i         ),
    .valid_i  ( mul_in_valid  ),
    .ready_o  ( mul_in_ready  ),
    .op_i     ( req_i.op      ),
    .a_i      ( req_i.arga    ),
    .b_i      ( req_i.argb    ),
    .id_i     ( req_i.id      ),
    .valid_o  ( mul_out_valid ),
    .ready_i  ( mul_out_ready ),
    .result_o ( mul_result    ),
    .id_o     ( mul_id        )
  );

  muldiv_divider muldiv_divider_inst (
    .clk_i    ( clk_i         ),
    .rst_i    ( rst_i         ),
    .valid_i  ( div_in_valid  ),
    .ready_o  ( div_in_ready  ),
    .op_i     ( req_i.op      ),
    .a_i      ( req_i.arga    ),
    .b_i      ( req_i.argb    ),
    .id_i     ( req_i.id      ),
    .valid_o  ( div_out_valid ),
    .ready_i  ( div_out_ready ),
    .result_o ( div_result    ),
    .id_o     ( div_id        )
  );

  // One-entry slot for requests to a wrong address
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_full_q <= 1'b0;
    end else if (err_accept) begin
      err_full_q <= 1'b1;
    end else if (err_full_q && resp_ready_i) begin
      err_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (err_accept) begin
      err_id_q <= req_i.id;
    end
  end

  // ----------------------------------------
  // Response arbitration
  // ----------------------------------------
  // Fixed priority, error first, divider last
  assign mul_out_ready = resp_ready_i && !err_full_q;
  assign div_out_ready = resp_ready_i && !err_full_q && !mul_out_valid;
  assign resp_valid_o  = err_full_q || mul_out_valid || div_out_valid;

  always_comb begin
    if (err_full_q) begin
      resp_o.data  = '0;
      resp_o.id    = err_id_q;
      resp_o.error = 1'b1;
    end else if (mul_out_valid) begin
      resp_o.data  = mul_result;
      resp_o.id    = mul_id;
      resp_o.error = 1'b0;
    end else begin
      resp_o.data  = div_result;
      resp_o.id    = div_id;
      resp_o.error = 1'b0;
    end
  end

endmodule

// ==== source/core_complex.sv ====
module core_complex import cc_types_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  // Offload port
  input  acc_req_t  acc_req_i,
  input  logic      acc_qvalid_i,
  output logic      acc_qready_o,
  output acc_resp_t acc_resp_o,
  output logic      acc_pvalid_o,
  input  logic      acc_pready_i,
  // Core-side data port
  input  dreq_t     core_dreq_i,
  input  logic      core_dqvalid_i,
  output logic      core_dqready_o,
  output dresp_t    core_dresp_o,
  output logic      core_dpvalid_o,
  input  logic      core_dpready_i,
  // Memory-side data port
  output dreq_t     mem_dreq_o,
  output logic      mem_dqvalid_o,
  input  logic      mem_dqready_i,
  input  dresp_t    mem_dresp_i,
  input  logic      mem_dpvalid_i,
  output logic      mem_dpready_o
);

  acc_req_t  acc_req_q;
  acc_resp_t acc_resp_d;
  logic      acc_req_q_valid, acc_req_q_ready;
  logic      acc_resp_d_valid, acc_resp_d_ready;

  // ----------------------------------------
  // Offload path
  // ----------------------------------------
  spill_register #(
    .T      ( acc_req_t        ),
    .BYPASS ( !REG_OFFLOAD_REQ )
  ) spill_acc_req_inst (
    .clk_i   ( clk_i           ),
    .rst_i   ( rst_i           ),
    .valid_i ( acc_qvalid_i    ),
    .ready_o ( acc_qready_o    ),
    .data_i  ( acc_req_i       ),
    .valid_o ( acc_req_q_valid ),
    .ready_i ( acc_req_q_ready ),
    .data_o  ( acc_req_q       )
  );

  shared_muldiv shared_muldiv_inst (
    .clk_i        ( clk_i            ),
    .rst_i        ( rst_i            ),
    .req_i        ( acc_req_q        ),
    .req_valid_i  ( acc_req_q_valid  ),
    .req_ready_o  ( acc_req_q_ready  ),
    .resp_o       ( acc_resp_d       ),
    .resp_valid_o ( acc_resp_d_valid ),
    .resp_ready_i ( acc_resp_d_ready )
  );

  spill_register #(
    .T      ( acc_resp_t        ),
    .BYPASS ( !REG_OFFLOAD_RESP )
  ) spill_acc_resp_inst (
    .clk_i   ( clk_i            ),
    .rst_i   ( rst_i            ),
    .valid_i ( acc_resp_d_valid ),
    .ready_o ( acc_resp_d_ready ),
    .data_i  ( acc_resp_d       ),
    .valid_o ( acc_pvalid_o     ),
    .ready_i ( acc_pready_i     ),
    .data_o  ( acc_resp_o       )
  );

  // ----------------------------------------
  // TCDM paths
  // ----------------------------------------
  spill_register #(
    .T      ( dreq_t        ),
    .BYPASS ( !REG_TCDM_REQ )
  ) spill_tcdm_req_inst (
    .clk_i   ( clk_i          ),
    .rst_i   ( rst_i          ),
    .valid_i ( core_dqvalid_i ),
    .ready_o ( core_dqready_o ),
    .data_i  ( core_dreq_i    ),
    .valid_o ( mem_dqvalid_o  ),
    .ready_i ( mem_dqready_i  ),
    .data_o  ( mem_dreq_o     )
  );

  spill_register #(
    .T      ( dresp_t        ),
    .BYPASS ( !REG_TCDM_RESP )
  ) spill_tcdm_resp_inst (
    .clk_i   ( clk_i          ),
    .rst_i   ( rst_i          ),
    .valid_i ( mem_dpvalid_i  ),
    .ready_o ( mem_dpready_o  ),
    .data_i  ( mem_dresp_i    ),
    .valid_o ( core_dpvalid_o ),
    .ready_i ( core_dpready_i ),
    .data_o  ( core_dresp_o   )
  );

endmodule

// ==== sim/tb_core_complex.sv ====
module tb_core_complex import muldiv_pkg::*, cc_types_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 2000;
  localparam int NUM_IDS        = 2 ** ACC_ID_WIDTH;

  logic      clk_i;
  logic      rst_i;
  acc_req_t  acc_req_i;
  logic      acc_qvalid_i;
  logic      acc_qready_o;
  acc_resp_t acc_resp_o;
  logic      acc_pvalid_o;
  logic      acc_pready_i;
  dreq_t     core_dreq_i;
  logic      core_dqvalid_i;
  logic      core_dqready_o;
  dresp_t    core_dresp_o;
  logic      core_dpvalid_o;
  logic      core_dpready_i;
  dreq_t     mem_dreq_o;
  logic      mem_dqvalid_o;
  logic      mem_dqready_i;
  dresp_t    mem_dresp_i;
  logic      mem_dpvalid_i;
  logic      mem_dpready_o;

  // Scoreboard with one slot per response id
  acc_resp_t exp_resp [NUM_IDS];
  string     exp_name [NUM_IDS];
  bit        pending  [NUM_IDS];
  int        n_pending;
  int        n_tests;
  int        n_wrong;
  int        n_other;

  core_complex core_complex_inst (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // Result checks
  // ----------------------------------------
  task automatic check_acc_resp(input string name, input acc_resp_t exp_v,
                                input acc_resp_t act_v, output bit ok);
    ok = (act_v === exp_v);
    if (!ok) begin
      $display("[FAIL] %s expected data=%h id=%0d error=%b actual data=%h id=%0d error=%b",
               name, exp_v.data, exp_v.id, exp_v.error, act_v.data, act_v.id, act_v.error);
    end
  endtask

  task automatic check_mem_dreq(input string name, input dreq_t exp_v, input dreq_t act_v,
                                output bit ok);
    string exp_s;
    string act_s;
    ok = (act_v === exp_v);
    if (!ok) begin
      exp_s = $sformatf("addr=%h we=%b amo=%h data=%h strb=%h",
                        exp_v.addr, exp_v.write, exp_v.amo, exp_v.data, exp_v.strb);
      act_s = $sformatf("addr=%h we=%b amo=%h data=%h strb=%h",
                        act_v.addr, act_v.write, act_v.amo, act_v.data, act_v.strb);
      $display("[FAIL] %s expected %s actual %s", name, exp_s, act_s);
    end
  endtask

  task automatic check_core_dresp(input string name, input dresp_t exp_v,
                                  input dresp_t act_v, output bit ok);
    ok = (act_v === exp_v);
    if (!ok) begin
      $display("[FAIL] %s expected data=%h error=%b actual data=%h error=%b",
               name, exp_v.data, exp_v.error, act_v.data, act_v.error);
    end
  endtask

  task automatic record_result(input string name, input bit ok);
    n_tests++;
    if (ok) begin
      $display("[PASS] %s", name);
    end else begin
      n_wrong++;
    end
  endtask

  task automatic verify_idle_after_reset();
    bit ok;
    @(negedge clk_i);
    ok = !acc_pvalid_o && !core_dpvalid_o && !mem_dqvalid_o && acc_qready_o;
    if (!ok) begin
      $display("a valid output is high or a ready is low right after reset");
    end
    record_result("reset_state", ok);
  endtask

  // ----------------------------------------
  // Offload port
  // ----------------------------------------
  task automatic send_acc(input acc_req_t req);
    int cnt;
    @(posedge clk_i);
    acc_req_i    <= req;
    acc_qvalid_i <= 1'b1;
    cnt = 0;
    do begin
      @(negedge clk_i);
      cnt++;
    end while (!acc_qready_o && cnt < TIMEOUT_CYCLES);
    if (!acc_qready_o) begin
      $display("request with id %0d not accepted within %0d cycles", req.id, TIMEOUT_CYCLES);
      n_other++;
    end
    @(posedge clk_i);
    acc_qvalid_i <= 1'b0;
  endtask

  task automatic wait_all_responses();
    int cnt;
    cnt = 0;
    while (n_pending != 0 && cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cnt++;
    end
    if (n_pending != 0) begin
      for (int i = 0; i < NUM_IDS; i++) begin
        if (pending[i]) begin
          $display("no response for id %0d (%s) within %0d cycles",
                   i, exp_name[i], TIMEOUT_CYCLES);
          pending[i] = 1'b0;
          n_other++;
        end
      end
      n_pending = 0;
    end
  endtask

  // Random back-pressure on the response port
  initial begin : stall_responses
    int unsigned seed;
    seed = 32'h66eb;
    void'($urandom(seed));
    forever begin
      @(posedge clk_i);
      acc_pready_i <= ($urandom % 4) != 0;
    end
  end

  // Transfer happens at the next rising edge, so sample on the falling one
  initial begin : collect_responses
    acc_resp_t resp;
    bit        ok;
    forever begin
      @(negedge clk_i);
      if (acc_pvalid_o && acc_pready_i) begin
        resp = acc_resp_o;
        if (!pending[resp.id]) begin
          $display("unexpected or repeated response with id %0d", resp.id);
          n_other++;
        end else begin
          pending[resp.id] = 1'b0;
          n_pending--;
          check_acc_resp(exp_name[resp.id], exp_resp[resp.id], resp, ok);
          record_result(exp_name[resp.id], ok);
        end
      end
    end
  end

  // ----------------------------------------
  // Data port with the testbench acting as memory
  // ----------------------------------------
  task automatic run_mem_test(input string name, input dreq_t req, input dresp_t resp);
    int cnt;
    bit ok_req;
    bit ok_resp;
    ok_req  = 1'b0;
    ok_resp = 1'b0;
    @(posedge clk_i);
    core_dreq_i    <= req;
    core_dqvalid_i <= 1'b1;
    mem_dqready_i  <= 1'b1;
    cnt = 0;
    do begin
      @(negedge clk_i);
      cnt++;
    end while (!core_dqready_o && cnt < TIMEOUT_CYCLES);
    // Request path has no register, so memory sees it in the same cycle
    if (!core_dqready_o) begin
      $display("request of %s not accepted within %0d cycles", name, TIMEOUT_CYCLES);
      n_other++;
    end else if (!mem_dqvalid_o) begin
      $display("request of %s did not appear on the memory side", name);
      n_other++;
    end else begin
      check_mem_dreq(name, req, mem_dreq_o, ok_req);
    end
    @(posedge clk_i);
    core_dqvalid_i <= 1'b0;
    mem_dqready_i  <= 1'b0;
    mem_dresp_i    <= resp;
    mem_dpvalid_i  <= 1'b1;
    core_dpready_i <= 1'b1;
    cnt = 0;
    do begin
      @(negedge clk_i);
      cnt++;
    end while (!mem_dpready_o && cnt < TIMEOUT_CYCLES);
    if (!mem_dpready_o) begin
      $display("memory response of %s not accepted within %0d cycles", name, TIMEOUT_CYCLES);
      n_other++;
    end
    @(posedge clk_i);
    mem_dpvalid_i <= 1'b0;
    cnt = 0;
    do begin
      @(negedge clk_i);
      cnt++;
    end while (!core_dpvalid_o && cnt < TIMEOUT_CYCLES);
    if (!core_dpvalid_o) begin
      $display("no core response for %s within %0d cycles", name, TIMEOUT_CYCLES);
      n_other++;
    end else begin
      check_core_dresp(name, resp, core_dresp_o, ok_resp);
    end
    @(posedge clk_i);
    core_dpready_i <= 1'b0;
    record_result(name, ok_req && ok_resp);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin : main
    int          fd;
    int          n;
    string       line;
    string       kind;
    string       name;
    logic [31:0] op, addr, id, arga, argb, expv;
    acc_req_t    req;
    acc_resp_t   exp_v;
    dreq_t       dreq;
    dresp_t      dresp;

    rst_i          = 1'b1;
    acc_req_i      = '0;
    acc_qvalid_i   = 1'b0;
    acc_pready_i   = 1'b0;
    core_dreq_i    = '0;
    core_dqvalid_i = 1'b0;
    core_dpready_i = 1'b0;
    mem_dqready_i  = 1'b0;
    mem_dresp_i    = '0;
    mem_dpvalid_i  = 1'b0;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    verify_idle_after_reset();

    fd = $fopen("sim/muldiv_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open vector file sim/muldiv_input.txt");
      n_other++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() < 2 || line[0] == "#") begin
          continue;
        end
        n = $sscanf(line, "%s %s %h %h %h %h %h %h", kind, name, op, addr, id, arga, argb,
                    expv);
        if (n != 8) begin
          $display("malformed vector line: %s", line);
          n_other++;
        end else if (kind == "acc") begin
          req.addr    = addr[ACC_ADDR_WIDTH-1:0];
          req.id      = id[ACC_ID_WIDTH-1:0];
          req.op      = muldiv_op_e'(op[3:0]);
          req.arga    = arga;
          req.argb    = argb;
          // Wrong unit address answers with zero data and the error bit
          exp_v.data  = expv;
          exp_v.id    = req.id;
          exp_v.error = (req.addr != MULDIV_ADDR);
          exp_resp[req.id] = exp_v;
          exp_name[req.id] = name;
          pending[req.id]  = 1'b1;
          n_pending++;
          send_acc(req);
        end else if (kind == "sync") begin
          wait_all_responses();
        end else if (kind == "mem") begin
          dreq.addr   = arga;
          dreq.write  = addr[0];
          dreq.amo    = op[3:0];
          dreq.data   = argb;
          dreq.strb   = id[3:0];
          dresp.data  = expv;
          // Memory model answers atomics with the error bit set
          dresp.error = (dreq.amo != 4'h0);
          run_mem_test(name, dreq, dresp);
        end else begin
          $display("unknown vector kind %s", kind);
          n_other++;
        end
      end
      $fclose(fd);
    end
    wait_all_responses();

    $display("%0d tests run, %0d wrong results, %0d other errors", n_tests, n_wrong, n_other);
    if (n_wrong == 0 && n_other == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== sim/muldiv_input.txt ====
# kind name op addr id arga argb expect, hex; op 0..7 = MUL MULH MULHSU MULHU DIV DIVU REM REMU
# mem: op=amo addr=write id=strb arga=address argb=wdata expect=rdata; sync waits for all ids
acc  mul_basic     0 0 01 00000007 00000006 0000002a
acc  mulh_neg      1 0 02 ffffffff ffffffff 00000000
acc  mulh_min      1 0 03 80000000 80000000 40000000
acc  mulhsu_neg    2 0 04 ffffffff ffffffff ffffffff
acc  mulhu_max     3 0 05 ffffffff ffffffff fffffffe
acc  mulh_mixed    1 0 06 80000000 00000002 ffffffff
sync grp_mul       0 0 00 00000000 00000000 00000000
acc  div_basic     4 0 01 00000014 00000006 00000003
acc  div_neg       4 0 02 fffffff9 00000002 fffffffd
acc  rem_neg       6 0 03 fffffff9 00000002 ffffffff
acc  divu_big      5 0 04 ffffffff 00000010 0fffffff
acc  remu_big      7 0 05 ffffffff 00000010 0000000f
acc  div_zero      4 0 06 00001234 00000000 ffffffff
acc  remu_zero     7 0 07 00001234 00000000 00001234
acc  div_ovf       4 0 08 80000000 ffffffff 80000000
acc  rem_ovf       6 0 09 80000000 ffffffff 00000000
sync grp_div       0 0 00 00000000 00000000 00000000
acc  burst_div     4 0 0a 00000064 00000007 0000000e
acc  burst_mul     0 0 0b 00000003 00000005 0000000f
acc  burst_mul_lo  0 0 0c 00010000 00010000 00000000
acc  burst_mulhu   3 0 0d 00010000 00010000 00000001
acc  burst_mul_wr  0 0 0e 12345678 00000010 23456780
sync grp_burst     0 0 00 00000000 00000000 00000000
acc  err_addr1     0 1 14 00000005 00000006 00000000
acc  err_addr3     4 3 15 00000064 00000007 00000000
acc  after_err     0 0 16 00000002 00000002 00000004
sync grp_err       0 0 00 00000000 00000000 00000000
mem  mem_read      0 0 f  00001000 00000000 cafef00d
mem  mem_write     0 1 3  00001004 12345678 00000000
mem  mem_amo       2 1 f  00001008 00000001 00000005

// ==== flist.f ====
source/muldiv_pkg.sv
source/cc_types_pkg.sv
source/spill_register.sv
source/muldiv_multiplier.sv
source/muldiv_divider.sv
source/shared_muldiv.sv
source/core_complex.sv
sim/tb_core_complex.sv

// ==== Bender.yml ====
package:
  name: core_complex

sources:
  # Packages first, then leaf modules, then the top level
  - source/muldiv_pkg.sv
  - source/cc_types_pkg.sv
  - source/spill_register.sv
  - source/muldiv_multiplier.sv
  - source/muldiv_divider.sv
  - source/shared_muldiv.sv
  - source/core_complex.sv

  - target: simulation
    files:
      - sim/tb_core_complex.sv
